// ==== include/conv_tile_macros.svh ====
`ifndef CONV_TILE_MACROS_SVH
`define CONV_TILE_MACROS_SVH

// output channels, one cell per channel
`define CT_NUM_CH 8

// APB widths
`define CT_APB_AW 8
`define CT_APB_DW 32

// register map
`define CT_REG_CTRL   8'h00
`define CT_REG_LEN    8'h04
`define CT_REG_STATUS 8'h08
`define CT_REG_BIAS0  8'h10

`endif

// ==== hdl/conv_data_pkg.sv ====
`include "conv_tile_macros.svh"

package conv_data_pkg;

  // operand and result widths
  typedef logic signed [7:0] act_t;
  typedef logic signed [7:0] wt_t;
  typedef logic signed [23:0] acc_t;
  typedef logic signed [15:0] bias_t;
  typedef logic signed [7:0] qout_t;
  typedef logic [2:0] ch_idx_t;

  // one host beat, one activation shared by all channels
  typedef struct packed {
    logic valid;
    act_t act;
    wt_t [`CT_NUM_CH-1:0] wt;
  } beat_t;

  // operands seen by a single cell
  typedef struct packed {
    logic valid;
    logic last;
    act_t act;
    wt_t wt;
  } lane_t;

  typedef struct packed {
    logic valid;
    ch_idx_t ch;
    qout_t value;
  } result_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    FLUSH,
    DRAIN
  } ctrl_state_e;

endpackage

// ==== hdl/conv_regs_pkg.sv ====
`include "conv_tile_macros.svh"

package conv_regs_pkg;

  typedef logic [`CT_APB_AW-1:0] reg_addr_t;

  // tile setup as seen by the datapath
  typedef struct packed {
    logic [15:0] len_m1;
    logic [4:0] shift;
    logic relu_en;
    conv_data_pkg::bias_t [`CT_NUM_CH-1:0] bias;
  } tile_cfg_t;

endpackage

// ==== hdl/conv_cfg_regs.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module conv_cfg_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_regs_pkg::reg_addr_t  paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`CT_APB_DW-1:0]     pwdata,
  output logic [`CT_APB_DW-1:0]     prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      busy,
  input  logic                      tile_done,
  output conv_regs_pkg::tile_cfg_t  cfg
);
  import conv_data_pkg::*;
  import conv_regs_pkg::*;

  localparam reg_addr_t BIAS_END = reg_addr_t'(`CT_REG_BIAS0 + 4 * `CT_NUM_CH);

  logic access;
  logic wr_en;
  logic hit_ctrl;
  logic hit_len;
  logic hit_status;
  logic hit_bias;
  logic mapped;
  logic wr_err;
  ch_idx_t bias_idx;
  logic [7:0] tile_cnt;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // no wait states
  assign pready = 1'b1;
  assign access = psel && penable && pready;

  assign hit_ctrl = (paddr == `CT_REG_CTRL);
  assign hit_len = (paddr == `CT_REG_LEN);
  assign hit_status = (paddr == `CT_REG_STATUS);
  assign hit_bias = (paddr >= `CT_REG_BIAS0) && (paddr < BIAS_END) && (paddr[1:0] == 2'b00);
  assign bias_idx = ch_idx_t'((paddr - `CT_REG_BIAS0) >> 2);
  assign mapped = hit_ctrl || hit_len || hit_status || hit_bias;

  // status is read only, setup is locked while a tile runs
  assign wr_err = pwrite && (hit_status || (busy && (hit_ctrl || hit_len || hit_bias)));
  assign pslverr = access && (!mapped || wr_err);
  assign wr_en = access && pwrite && mapped && !wr_err;

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg <= '0;
    end
    else if (wr_en)
    begin
      if (hit_ctrl)
      begin
        cfg.relu_en <= pwdata[0];
        cfg.shift <= pwdata[8:4];
      end
      if (hit_len)
        cfg.len_m1 <= pwdata[15:0];
      if (hit_bias)
        cfg.bias[bias_idx] <= bias_t'(pwdata[15:0]);
    end
  end

  // completed tiles
  always_ff @(posedge clk)
  begin
    if (reset)
      tile_cnt <= '0;
    else if (tile_done)
      tile_cnt <= tile_cnt + 8'd1;
  end

  always_comb
  begin
    prdata = '0;
    if (hit_ctrl)
    begin
      prdata[0] = cfg.relu_en;
      prdata[8:4] = cfg.shift;
    end
    else if (hit_len)
      prdata[15:0] = cfg.len_m1;
    else if (hit_status)
    begin
      prdata[0] = busy;
      prdata[15:8] = tile_cnt;
    end
    else if (hit_bias)
      prdata[15:0] = cfg.bias[bias_idx];
  end

  // access phase always follows a setup phase with psel held
  a_penable_psel: assert property (@(posedge clk) disable iff (reset)
    penable |-> psel);

endmodule

// ==== hdl/tile_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module tile_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    beat_valid,
  input  logic [15:0]             len_m1,
  output logic                    busy,
  output logic                    tile_done,
  output logic                    last,
  output logic                    drain_valid,
  output conv_data_pkg::ch_idx_t  drain_sel
);
  import conv_data_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic [15:0] pix_cnt;
  ch_idx_t flush_cnt;
  ch_idx_t ch_cnt;
  logic accept;
  logic flush_end;
  logic drain_end;
  logic [1:0] done_dly;

  // beats are only taken before the tile is closed
  assign accept = beat_valid && ((state == IDLE) || (state == ACCUM));
  assign last = accept && (pix_cnt == len_m1);

  // flush covers the skew of the last cell
  assign flush_end = (state == FLUSH) && (flush_cnt == ch_idx_t'(`CT_NUM_CH - 1));
  assign drain_end = (state == DRAIN) && (ch_cnt == ch_idx_t'(`CT_NUM_CH - 1));

  assign drain_valid = (state == DRAIN);
  assign drain_sel = ch_cnt;
  assign tile_done = done_dly[1];

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE, ACCUM:
      begin
        if (last)
          state_next = FLUSH;
        else if (accept)
          state_next = ACCUM;
      end
      FLUSH:
      begin
        if (flush_end)
          state_next = DRAIN;
      end
      DRAIN:
      begin
        if (drain_end)
          state_next = IDLE;
      end
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= IDLE;
    else
      state <= state_next;
  end

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  // pixel level, wraps on the final beat
  always_ff @(posedge clk)
  begin
    if (reset)
      pix_cnt <= '0;
    else if (last)
      pix_cnt <= '0;
    else if (accept)
      pix_cnt <= pix_cnt + 16'd1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      flush_cnt <= '0;
    else if (flush_end)
      flush_cnt <= '0;
    else if (state == FLUSH)
      flush_cnt <= flush_cnt + ch_idx_t'(1);
  end

  // channel slot level
  always_ff @(posedge clk)
  begin
    if (reset)
      ch_cnt <= '0;
    else if (drain_end)
      ch_cnt <= '0;
    else if (state == DRAIN)
      ch_cnt <= ch_cnt + ch_idx_t'(1);
  end

  // matches the two drain stages
  always_ff @(posedge clk)
  begin
    if (reset)
      done_dly <= '0;
    else
      done_dly <= {done_dly[0], drain_end};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      busy <= 1'b0;
    else if (accept && (state == IDLE))
      busy <= 1'b1;
    else if (done_dly[0])
      busy <= 1'b0;
  end

  a_beat_window: assert property (@(posedge clk) disable iff (reset)
    beat_valid |-> ((state == IDLE) || (state == ACCUM)));

endmodule

// ==== hdl/operand_skew.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module operand_skew (
  input  logic                                    clk,
  input  logic                                    reset,
  input  conv_data_pkg::beat_t                    beat,
  input  logic                                    last,
  output conv_data_pkg::lane_t [`CT_NUM_CH-1:0]   lanes
);
  import conv_data_pkg::*;

  logic [`CT_NUM_CH-1:0] vld_q;
  logic [`CT_NUM_CH-1:0] last_q;
  act_t [`CT_NUM_CH-1:0] act_q;

  // control bits march one cell per cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld_q <= '0;
      last_q <= '0;
    end
    else
    begin
      vld_q <= {vld_q[`CT_NUM_CH-2:0], beat.valid};
      last_q <= {last_q[`CT_NUM_CH-2:0], last};
    end
  end

  always_ff @(posedge clk)
  begin
    act_q <= {act_q[`CT_NUM_CH-2:0], beat.act};
  end

  ////////////////////////////////////////////////////////////
  // weight delay, i extra stages for cell i
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `CT_NUM_CH; i++)
  begin : g_wt
    wt_t wt_q;

    if (i == 0)
    begin : g_direct
      always_ff @(posedge clk)
      begin
        wt_q <= beat.wt[0];
      end
    end
    else
    begin : g_delay
      wt_t dly [i];

      always_ff @(posedge clk)
      begin
        dly[0] <= beat.wt[i];
        for (int k = 1; k < i; k++)
          dly[k] <= dly[k-1];
        wt_q <= dly[i-1];
      end
    end

    assign lanes[i] = '{valid: vld_q[i], last: last_q[i], act: act_q[i], wt: wt_q};
  end

endmodule

// ==== hdl/mac_cell.sv ====
`timescale 1ns/1ps

module mac_cell (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_data_pkg::lane_t  lane,
  output conv_data_pkg::acc_t   sum
);
  import conv_data_pkg::*;

  logic signed [15:0] prod;
  acc_t acc;
  acc_t acc_next;

  assign prod = lane.act * lane.wt;
  assign acc_next = acc + acc_t'(prod);

  // running sum, restarts after the last beat
  always_ff @(posedge clk)
  begin
    if (reset)
      acc <= '0;
    else if (lane.valid)
    begin
      if (lane.last)
        acc <= '0;
      else
        acc <= acc_next;
    end
  end

  // final sum held until the next tile closes
  always_ff @(posedge clk)
  begin
    if (lane.valid && lane.last)
      sum <= acc_next;
  end

endmodule

// ==== hdl/channel_drain.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module channel_drain (
  input  logic                                  clk,
  input  logic                                  reset,
  input  conv_regs_pkg::tile_cfg_t              cfg,
  input  conv_data_pkg::acc_t [`CT_NUM_CH-1:0]  sums,
  input  logic                                  drain_valid,
  input  conv_data_pkg::ch_idx_t                drain_sel,
  output conv_data_pkg::result_t                result
);
  import conv_data_pkg::*;

  logic signed [24:0] biased;
  logic signed [24:0] shifted;
  logic signed [24:0] s1_val;
  logic s1_valid;
  ch_idx_t s1_ch;
  qout_t sat;
  logic res_valid;
  ch_idx_t res_ch;
  qout_t res_value;

  ////////////////////////////////////////////////////////////
  // first stage adds bias and shifts
  ////////////////////////////////////////////////////////////

  // one extra bit so the bias add cannot wrap
  assign biased = 25'(sums[drain_sel]) + 25'(cfg.bias[drain_sel]);
  assign shifted = biased >>> cfg.shift;

  always_ff @(posedge clk)
  begin
    if (reset)
      s1_valid <= 1'b0;
    else
      s1_valid <= drain_valid;
  end

  always_ff @(posedge clk)
  begin
    s1_val <= shifted;
    s1_ch <= drain_sel;
  end

  ////////////////////////////////////////////////////////////
  // second stage saturates and applies relu
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    if (s1_val > 25'sd127)
      sat = 8'sd127;
    else if (s1_val < -25'sd128)
      sat = -8'sd128;
    else
      sat = qout_t'(s1_val);
    if (cfg.relu_en && (sat < 0))
      sat = '0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      res_valid <= 1'b0;
    else
      res_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    res_ch <= s1_ch;
    res_value <= sat;
  end

  assign result = '{valid: res_valid, ch: res_ch, value: res_value};

  // selects within one drain run step through the channels in order
  a_sel_step: assert property (@(posedge clk) disable iff (reset)
    (drain_valid && $past(drain_valid)) |-> (drain_sel == ch_idx_t'($past(drain_sel) + 1)));

endmodule

// ==== hdl/conv_tile_top.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module conv_tile_top (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_regs_pkg::reg_addr_t  paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`CT_APB_DW-1:0]     pwdata,
  output logic [`CT_APB_DW-1:0]     prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  conv_data_pkg::beat_t      beat,
  output conv_data_pkg::result_t    result,
  output logic                      tile_done
);
  import conv_data_pkg::*;
  import conv_regs_pkg::*;

  tile_cfg_t cfg;
  logic busy;
  logic last;
  logic drain_valid;
  ch_idx_t drain_sel;
  lane_t [`CT_NUM_CH-1:0] lanes;
  acc_t [`CT_NUM_CH-1:0] sums;

  ////////////////////////////////////////////////////////////
  // configuration and control
  ////////////////////////////////////////////////////////////

  conv_cfg_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .busy      (busy),
    .tile_done (tile_done),
    .cfg       (cfg)
  );

  tile_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .beat_valid  (beat.valid),
    .len_m1      (cfg.len_m1),
    .busy        (busy),
    .tile_done   (tile_done),
    .last        (last),
    .drain_valid (drain_valid),
    .drain_sel   (drain_sel)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  operand_skew u_skew (
    .clk   (clk),
    .reset (reset),
    .beat  (beat),
    .last  (last),
    .lanes (lanes)
  );

  // one cell per output channel
  for (genvar i = 0; i < `CT_NUM_CH; i++)
  begin : g_cell
    mac_cell u_cell (
      .clk   (clk),
      .reset (reset),
      .lane  (lanes[i]),
      .sum   (sums[i])
    );
  end

  channel_drain u_drain (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg),
    .sums        (sums),
    .drain_valid (drain_valid),
    .drain_sel   (drain_sel),
    .result      (result)
  );

endmodule

// ==== verification/conv_tile_tb.sv ====
`timescale 1ns/1ps
`include "conv_tile_macros.svh"

module conv_tile_tb;
  import conv_data_pkg::*;
  import conv_regs_pkg::*;

  localparam int NUM_TILES = 3;
  localparam int TILE_LEN = 20;
  localparam int MAX_RESULTS = NUM_TILES * `CT_NUM_CH;
  localparam int WATCHDOG_NS = NUM_TILES * (TILE_LEN + `CT_NUM_CH + 10) * 10 + 2000;

  logic clk = 1'b0;
  logic reset;
  reg_addr_t paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`CT_APB_DW-1:0] pwdata;
  logic [`CT_APB_DW-1:0] prdata;
  logic pready;
  logic pslverr;
  beat_t beat;
  result_t result;
  logic tile_done;

  // operands of the current tile and the expected results
  logic [31:0] rng_state = 32'he84b;
  logic [31:0] rdata;
  act_t act_mem [TILE_LEN];
  wt_t wt_mem [TILE_LEN][`CT_NUM_CH];
  bias_t bias_val [`CT_NUM_CH];
  ch_idx_t exp_ch [MAX_RESULTS];
  qout_t exp_val [MAX_RESULTS];
  int exp_count = 0;
  int rd_ptr = 0;
  int tiles_done = 0;
  int cur_shift = 0;
  bit cur_relu = 1'b0;
  bit stream_started = 1'b0;
  bit relu_check = 1'b0;
  bit sat_check = 1'b0;
  string test_name = "reset";

  conv_tile_top dut (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .beat      (beat),
    .result    (result),
    .tile_done (tile_done)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // failure reporting and reference model
  ////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_problem(input string what);
    $display("[ERROR] %s", what);
    stop_on_failure();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bias add, arithmetic shift, int8 saturation, optional relu
  function automatic qout_t quantize(input int sum, input int bias, input int shift,
                                     input bit relu);
    int v;
    v = (sum + bias) >>> shift;
    if (v > 127)
      v = 127;
    else if (v < -128)
      v = -128;
    if (relu && (v < 0))
      v = 0;
    return qout_t'(v);
  endfunction

  ////////////////////////////////////////////////////////////
  // APB and beat stream
  ////////////////////////////////////////////////////////////

  task automatic apb_write(input reg_addr_t addr, input logic [31:0] data, input logic exp_err);
    logic err;
    @(negedge clk);
    paddr = addr;
    pwrite = 1'b1;
    pwdata = data;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    assert (err == exp_err)
      else report_mismatch({test_name, " write pslverr"}, int'(exp_err), int'(err));
  endtask

  task automatic apb_read(input reg_addr_t addr, output logic [31:0] data,
                          input logic exp_err);
    logic err;
    @(negedge clk);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    assert (err == exp_err)
      else report_mismatch({test_name, " read pslverr"}, int'(exp_err), int'(err));
  endtask

  task automatic check_read(input reg_addr_t addr, input logic [31:0] expected);
    logic [31:0] data;
    apb_read(addr, data, 1'b0);
    assert (data == expected)
      else report_mismatch({test_name, " readback"}, int'(expected), int'(data));
  endtask

  task automatic set_ctrl(input int shift, input bit relu);
    logic [31:0] word;
    word = '0;
    word[8:4] = shift[4:0];
    word[0] = relu;
    cur_shift = shift;
    cur_relu = relu;
    apb_write(`CT_REG_CTRL, word, 1'b0);
  endtask

  // random operands or positive activations against +-127 weights
  task automatic prepare_tile(input bit saturate);
    int sum;
    for (int b = 0; b < TILE_LEN; b++)
    begin
      rng_state = xorshift32(rng_state);
      if (saturate)
        act_mem[b] = act_t'(64 + rng_state[5:0]);
      else
        act_mem[b] = act_t'($signed(rng_state[3:0]));
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        rng_state = xorshift32(rng_state);
        if (saturate)
          wt_mem[b][c] = (c % 2 == 0) ? 8'sd127 : -8'sd127;
        else
          wt_mem[b][c] = wt_t'($signed(rng_state[5:0]));
      end
    end
    for (int c = 0; c < `CT_NUM_CH; c++)
    begin
      sum = 0;
      for (int b = 0; b < TILE_LEN; b++)
        sum += int'(act_mem[b]) * int'(wt_mem[b][c]);
      exp_ch[exp_count] = ch_idx_t'(c);
      exp_val[exp_count] = quantize(sum, int'(bias_val[c]), cur_shift, cur_relu);
      exp_count++;
    end
  endtask

  task automatic stream_beats();
    for (int b = 0; b < TILE_LEN; b++)
    begin
      @(negedge clk);
      stream_started = 1'b1;
      beat.valid = 1'b1;
      beat.act = act_mem[b];
      for (int c = 0; c < `CT_NUM_CH; c++)
        beat.wt[c] = wt_mem[b][c];
    end
    @(negedge clk);
    beat = '0;
  endtask

  task automatic finish_tile();
    logic [31:0] status;
    while (!tile_done)
      @(negedge clk);
    tiles_done++;
    apb_read(`CT_REG_STATUS, status, 1'b0);
    assert (status[15:8] == tiles_done[7:0])
      else report_mismatch({test_name, " status tile count"}, tiles_done,
                           int'(status[15:8]));
    assert (status[0] == 1'b0)
      else report_problem("busy still set after tile_done");
  endtask

  ////////////////////////////////////////////////////////////
  // result checks
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (reset)
      rd_ptr <= 0;
    else if (result.valid)
      rd_ptr <= rd_ptr + 1;
  end

  a_result_expected: assert property (@(negedge clk) disable iff (reset)
    result.valid |-> (rd_ptr < exp_count))
    else report_problem("a result came out with no expected value pending");

  a_result_channel: assert property (@(negedge clk) disable iff (reset)
    result.valid |-> (result.ch == exp_ch[rd_ptr]))
    else report_mismatch({test_name, " channel"}, int'(exp_ch[rd_ptr]), int'(result.ch));

  a_result_value: assert property (@(negedge clk) disable iff (reset)
    result.valid |-> (result.value == exp_val[rd_ptr]))
    else report_mismatch({test_name, " value"}, int'(exp_val[rd_ptr]), int'(result.value));

  // tile_done rides on the last channel
  a_done_last: assert property (@(negedge clk) disable iff (reset)
    tile_done |-> (result.valid && (result.ch == ch_idx_t'(`CT_NUM_CH - 1))))
    else report_problem("tile_done without the result of the last channel");

  a_quiet_before_stream: assert property (@(negedge clk) disable iff (reset)
    !stream_started |-> (!result.valid && !tile_done))
    else report_problem("result or tile_done active before any beat");

  a_relu_nonneg: assert property (@(negedge clk) disable iff (reset)
    (result.valid && relu_check) |-> !result.value[7])
    else report_mismatch({test_name, " relu sign"}, 0, int'(result.value));

  a_sat_limits: assert property (@(negedge clk) disable iff (reset)
    (result.valid && sat_check) |-> ((result.value == 8'sd127) || (result.value == -8'sd128)))
    else report_mismatch({test_name, " limit"}, int'(exp_val[rd_ptr]), int'(result.value));

  a_pready_high: assert property (@(negedge clk) disable iff (reset) pready)
    else report_problem("pready went low");

  initial
  begin
    #(WATCHDOG_NS);
    report_problem("watchdog timeout, the tiles did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    beat = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // the biases written here stay for every tile
    test_name = "regs";
    for (int c = 0; c < `CT_NUM_CH; c++)
    begin
      rng_state = xorshift32(rng_state);
      bias_val[c] = bias_t'($signed(rng_state[9:0]));
    end
    apb_write(`CT_REG_CTRL, 32'h0000_01a1, 1'b0);
    check_read(`CT_REG_CTRL, 32'h0000_01a1);
    apb_write(`CT_REG_LEN, 32'h0000_5a3c, 1'b0);
    check_read(`CT_REG_LEN, 32'h0000_5a3c);
    for (int c = 0; c < `CT_NUM_CH; c++)
      apb_write(reg_addr_t'(`CT_REG_BIAS0 + 4 * c), {16'h0, bias_val[c]}, 1'b0);
    for (int c = 0; c < `CT_NUM_CH; c++)
      check_read(reg_addr_t'(`CT_REG_BIAS0 + 4 * c), {16'h0, bias_val[c]});
    apb_read(8'h0c, rdata, 1'b1);
    apb_write(8'h40, 32'h0000_0001, 1'b1);
    apb_write(`CT_REG_STATUS, 32'h0000_ff00, 1'b1);
    check_read(`CT_REG_STATUS, 32'h0);

    test_name = "random";
    set_ctrl(4, 1'b0);
    apb_write(`CT_REG_LEN, TILE_LEN - 1, 1'b0);
    prepare_tile(1'b0);
    stream_beats();
    finish_tile();

    // relu tile with a length write attempted mid tile
    test_name = "relu";
    set_ctrl(3, 1'b1);
    prepare_tile(1'b0);
    relu_check = 1'b1;
    fork
      stream_beats();
      begin
        repeat (3) @(negedge clk);
        apb_write(`CT_REG_LEN, 32'd5, 1'b1);
        apb_read(`CT_REG_STATUS, rdata, 1'b0);
        assert (rdata[0] == 1'b1)
          else report_problem("busy not set while a tile runs");
      end
    join
    finish_tile();
    relu_check = 1'b0;
    check_read(`CT_REG_LEN, TILE_LEN - 1);

    test_name = "saturate";
    set_ctrl(0, 1'b0);
    prepare_tile(1'b1);
    sat_check = 1'b1;
    stream_beats();
    finish_tile();
    sat_check = 1'b0;

    repeat (4) @(negedge clk);
    if ((rd_ptr == exp_count) && (exp_count == MAX_RESULTS))
    begin
      $display("Test passed");
      $finish;
    end
    else
      report_problem("not every expected result came out");
  end

endmodule

// ==== conv_tile_top.f ====
+incdir+include
hdl/conv_data_pkg.sv
hdl/conv_regs_pkg.sv
hdl/conv_cfg_regs.sv
hdl/tile_ctrl.sv
hdl/operand_skew.sv
hdl/mac_cell.sv
hdl/channel_drain.sv
hdl/conv_tile_top.sv
verification/conv_tile_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_tile_tb -f conv_tile_top.f

./obj_dir/Vconv_tile_tb | tee sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
